//--- include/elem_defs.svh
/*
 * Element unit widths
 * register, scalar and counter sizes shared by the package and the RTL
 */

`ifndef ELEM_DEFS_SVH
`define ELEM_DEFS_SVH

// vector register width in bits and its byte-enable width
`define ELEM_VREG_W 128
`define ELEM_VMSK_W 16

// scalar result and element datapath width
`define ELEM_XLEN 32

// vector length field
`define ELEM_VL_W 8

// element byte counter, register index on top of byte-in-register
`define ELEM_CNT_W 7
`define ELEM_LOW_W 4

`endif

//--- rtl/elem_pkg.sv
/*
 * Element unit types
 * operation encodings, counters and the records passed between stages
 */

`include "elem_defs.svh"

package elem_pkg;

    typedef enum logic [3:0] {
        ELEM_XMV     = 4'd0,
        ELEM_REDSUM  = 4'd1,
        ELEM_REDAND  = 4'd2,
        ELEM_REDOR   = 4'd3,
        ELEM_REDXOR  = 4'd4,
        ELEM_REDMINU = 4'd5,
        ELEM_REDMIN  = 4'd6,
        ELEM_REDMAXU = 4'd7,
        ELEM_REDMAX  = 4'd8,
        ELEM_VID     = 4'd9
    } elem_op_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } elem_sew_e;

    typedef enum logic [1:0] {
        EMUL_1 = 2'd0,
        EMUL_2 = 2'd1,
        EMUL_4 = 2'd2,
        EMUL_8 = 2'd3
    } elem_emul_e;

    // byte counter, read whole or split into register index and byte position
    typedef union packed {
        logic [`ELEM_CNT_W-1:0] val;
        struct packed {
            logic [`ELEM_CNT_W-`ELEM_LOW_W-1:0] mul;
            logic [`ELEM_LOW_W-1:0]             low;
        } part;
    } elem_cnt_u;

    typedef struct packed {
        elem_op_e              op;
        elem_sew_e             sew;
        elem_emul_e            emul;
        logic [`ELEM_VL_W-1:0] vl;
        logic [4:0]            vs2;
        logic [4:0]            vd;
    } elem_op_t;

    typedef struct packed {
        logic       valid;
        logic       first;
        logic       last;
        elem_op_e   op;
        elem_sew_e  sew;
        elem_cnt_u  cnt;
        logic       vl_hit;
        logic [4:0] vs2;
        logic [4:0] vd;
    } elem_stage_t;

    typedef struct packed {
        logic                  valid;
        logic [`ELEM_XLEN-1:0] data;
        logic                  be;
        logic                  first;
        logic                  last;
        elem_op_e              op;
        elem_sew_e             sew;
        logic [4:0]            vd;
    } elem_res_t;

    // element size in bytes
    function automatic logic [`ELEM_CNT_W-1:0] sew_bytes(elem_sew_e sew);
        case (sew)
            SEW_16:  return `ELEM_CNT_W'd2;
            SEW_32:  return `ELEM_CNT_W'd4;
            default: return `ELEM_CNT_W'd1;
        endcase
    endfunction

    // counter start points at the top byte of element 0
    function automatic logic [`ELEM_CNT_W-1:0] cnt_start(elem_sew_e sew);
        case (sew)
            SEW_16:  return `ELEM_CNT_W'd1;
            SEW_32:  return `ELEM_CNT_W'd3;
            default: return `ELEM_CNT_W'd0;
        endcase
    endfunction

endpackage

//--- rtl/elem_decode.sv
/*
 * Element unit decode
 * accepts operations and issues one stage record per element
 */

`timescale 1ns/1ps

`include "elem_defs.svh"

module elem_decode (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  logic                   op_rdy_i,
    input  elem_pkg::elem_op_t     op_i,
    output logic                   op_ack_o,
    output elem_pkg::elem_stage_t  stage_o
);

    logic                  busy_q, busy_d;
    logic                  first_q, first_d;
    elem_pkg::elem_op_t    op_q, op_d;
    elem_pkg::elem_cnt_u   cnt_q, cnt_d;
    logic                  mul_done;
    logic                  last;
    logic [`ELEM_VL_W-1:0] elem_idx;

    //////////////////////////////
    // state registers

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q  <= 1'b0;
            first_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            busy_q  <= busy_d;
            first_q <= first_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        op_q <= op_d;
    end

    //////////////////////////////
    // last element detection

    // register index part must reach the end of the group
    always_comb begin
        case (op_q.emul)
            elem_pkg::EMUL_2: mul_done = cnt_q.part.mul[0];
            elem_pkg::EMUL_4: mul_done = &cnt_q.part.mul[1:0];
            elem_pkg::EMUL_8: mul_done = &cnt_q.part.mul;
            default:          mul_done = 1'b1;
        endcase
    end

    // a move only reads element 0
    assign last = (op_q.op == elem_pkg::ELEM_XMV) | ((cnt_q.part.low == '1) & mul_done);

    assign op_ack_o = op_rdy_i & (~busy_q | last);

    //////////////////////////////
    // next state

    always_comb begin
        busy_d  = busy_q;
        first_d = 1'b0;
        op_d    = op_q;
        cnt_d   = cnt_q;
        if (op_ack_o) begin
            busy_d    = 1'b1;
            first_d   = 1'b1;
            op_d      = op_i;
            cnt_d.val = elem_pkg::cnt_start(op_i.sew);
        end else if (busy_q) begin
            busy_d    = ~last;
            cnt_d.val = cnt_q.val + elem_pkg::sew_bytes(op_q.sew);
        end
    end

    // element index from the byte counter
    assign elem_idx = `ELEM_VL_W'(cnt_q.val >> op_q.sew);

    always_comb begin
        stage_o.valid  = busy_q;
        stage_o.first  = first_q;
        stage_o.last   = busy_q & last;
        stage_o.op     = op_q.op;
        stage_o.sew    = op_q.sew;
        stage_o.cnt    = cnt_q;
        stage_o.vl_hit = elem_idx < op_q.vl;
        stage_o.vs2    = op_q.vs2;
        stage_o.vd     = op_q.vd;
    end

endmodule

//--- rtl/elem_operand.sv
/*
 * Element unit operand fetch
 * reads the source register and shifts out one element per cycle
 */

`timescale 1ns/1ps

`include "elem_defs.svh"

module elem_operand (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,
    input  elem_pkg::elem_stage_t   stage_i,
    input  logic [`ELEM_VREG_W-1:0] vreg_rd_i,
    output logic [4:0]              vreg_rd_addr_o,
    output elem_pkg::elem_stage_t   stage_o,
    output logic [`ELEM_XLEN-1:0]   elem_o
);

    elem_pkg::elem_stage_t   stage_q;
    logic [`ELEM_VREG_W-1:0] shift_q, shift_d;
    logic                    load;

    // register of the group holding the current element
    assign vreg_rd_addr_o = stage_i.vs2 + {2'b00, stage_i.cnt.part.mul};

    // first element of a register when the byte position holds only element 0
    assign load = (stage_i.cnt.part.low >> stage_i.sew) == '0;

    always_comb begin
        shift_d = vreg_rd_i;
        if (!load) begin
            case (stage_q.sew)
                elem_pkg::SEW_16: shift_d = shift_q >> 16;
                elem_pkg::SEW_32: shift_d = shift_q >> 32;
                default:          shift_d = shift_q >> 8;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            stage_q <= '0;
        end else begin
            stage_q <= stage_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_i.valid) begin
            shift_q <= shift_d;
        end
    end

    // element right-aligned and zero-extended
    always_comb begin
        case (stage_q.sew)
            elem_pkg::SEW_16: elem_o = {16'b0, shift_q[15:0]};
            elem_pkg::SEW_32: elem_o = shift_q[31:0];
            default:          elem_o = {24'b0, shift_q[7:0]};
        endcase
    end

    assign stage_o = stage_q;

endmodule

//--- rtl/elem_execute.sv
/*
 * Element unit execute
 * move, reduction and index results for each element
 */

`timescale 1ns/1ps

`include "elem_defs.svh"

module elem_execute (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,
    input  elem_pkg::elem_stage_t stage_i,
    input  logic [`ELEM_XLEN-1:0] elem_i,
    output elem_pkg::elem_res_t   res_o
);

    logic [`ELEM_XLEN-1:0] acc_q, acc_d;
    logic [`ELEM_XLEN-1:0] idx_q, idx_d;
    logic [`ELEM_XLEN-1:0] red;
    logic [`ELEM_XLEN-1:0] wmask;
    logic [`ELEM_XLEN-1:0] elem_s, acc_s;
    logic                  is_vid;
    elem_pkg::elem_res_t   res_d, res_q;

    function automatic logic [`ELEM_XLEN-1:0] sext_elem(
        input logic [`ELEM_XLEN-1:0] v,
        input elem_pkg::elem_sew_e   sew
    );
        case (sew)
            elem_pkg::SEW_8:  return {{24{v[7]}}, v[7:0]};
            elem_pkg::SEW_16: return {{16{v[15]}}, v[15:0]};
            default:          return v;
        endcase
    endfunction

    assign is_vid = stage_i.op == elem_pkg::ELEM_VID;

    always_comb begin
        case (stage_i.sew)
            elem_pkg::SEW_8:  wmask = 32'h0000_00ff;
            elem_pkg::SEW_16: wmask = 32'h0000_ffff;
            default:          wmask = 32'hffff_ffff;
        endcase
    end

    // signed views for min and max
    assign elem_s = sext_elem(elem_i, stage_i.sew);
    assign acc_s  = sext_elem(acc_q, stage_i.sew);

    //////////////////////////////
    // reduction

    always_comb begin
        case (stage_i.op)
            elem_pkg::ELEM_REDSUM:  red = acc_q + elem_i;
            elem_pkg::ELEM_REDAND:  red = acc_q & elem_i;
            elem_pkg::ELEM_REDOR:   red = acc_q | elem_i;
            elem_pkg::ELEM_REDXOR:  red = acc_q ^ elem_i;
            elem_pkg::ELEM_REDMINU: red = (elem_i < acc_q) ? elem_i : acc_q;
            elem_pkg::ELEM_REDMIN:  red = ($signed(elem_s) < $signed(acc_s)) ? elem_i : acc_q;
            elem_pkg::ELEM_REDMAXU: red = (elem_i > acc_q) ? elem_i : acc_q;
            elem_pkg::ELEM_REDMAX:  red = ($signed(elem_s) > $signed(acc_s)) ? elem_i : acc_q;
            default:                red = acc_q;
        endcase
    end

    // accumulator stays zero-extended at the element width
    always_comb begin
        acc_d = acc_q;
        if (stage_i.first) begin
            acc_d = elem_i;
        end else if (stage_i.vl_hit) begin
            acc_d = red & wmask;
        end
    end

    // running element index
    assign idx_d = stage_i.first ? `ELEM_XLEN'd1 : idx_q + `ELEM_XLEN'd1;

    always_ff @(posedge clk_i) begin
        if (stage_i.valid) begin
            acc_q <= acc_d;
        end
        if (stage_i.valid & is_vid) begin
            idx_q <= idx_d;
        end
    end

    //////////////////////////////
    // result record

    always_comb begin
        res_d.valid = stage_i.valid & (is_vid | stage_i.last);
        case (stage_i.op)
            elem_pkg::ELEM_XMV: res_d.data = elem_s;
            elem_pkg::ELEM_VID: res_d.data = stage_i.first ? '0 : idx_q;
            default:            res_d.data = sext_elem(acc_d, stage_i.sew);
        endcase
        res_d.be    = is_vid & stage_i.vl_hit;
        res_d.first = stage_i.first;
        res_d.last  = stage_i.last;
        res_d.op    = stage_i.op;
        res_d.sew   = stage_i.sew;
        res_d.vd    = stage_i.vd;
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            res_q <= '0;
        end else begin
            res_q <= res_d;
        end
    end

    assign res_o = res_q;

endmodule

//--- rtl/elem_result.sv
/*
 * Element unit result stage
 * collects index results into register writes and returns scalar results
 */

`timescale 1ns/1ps

`include "elem_defs.svh"

module elem_result (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,
    input  elem_pkg::elem_res_t     res_i,
    output logic                    vreg_wr_en_o,
    output logic [4:0]              vreg_wr_addr_o,
    output logic [`ELEM_VREG_W-1:0] vreg_wr_o,
    output logic [`ELEM_VMSK_W-1:0] vreg_wr_mask_o,
    output logic                    xreg_valid_o,
    output logic [`ELEM_XLEN-1:0]   xreg_o
);

    elem_pkg::elem_cnt_u     cnt_q, cnt_d;
    logic [`ELEM_VREG_W-1:0] vd_sh_q, vd_sh_d;
    logic [`ELEM_VMSK_W-1:0] msk_q, msk_d;
    logic                    store;
    logic                    wr_en_q;
    logic [4:0]              wr_addr_q;
    logic                    xreg_valid_q;
    logic [`ELEM_XLEN-1:0]   xreg_q;

    assign store = res_i.valid & (res_i.op == elem_pkg::ELEM_VID);

    // store counter restarts on the first element of each operation
    always_comb begin
        if (res_i.first) begin
            cnt_d.val = elem_pkg::cnt_start(res_i.sew);
        end else begin
            cnt_d.val = cnt_q.val + elem_pkg::sew_bytes(res_i.sew);
        end
    end

    // new element enters at the top, the oldest drops out at the bottom
    always_comb begin
        case (res_i.sew)
            elem_pkg::SEW_16: begin
                vd_sh_d = {res_i.data[15:0], vd_sh_q[`ELEM_VREG_W-1:16]};
                msk_d   = {{2{res_i.be}}, msk_q[`ELEM_VMSK_W-1:2]};
            end
            elem_pkg::SEW_32: begin
                vd_sh_d = {res_i.data, vd_sh_q[`ELEM_VREG_W-1:32]};
                msk_d   = {{4{res_i.be}}, msk_q[`ELEM_VMSK_W-1:4]};
            end
            default: begin
                vd_sh_d = {res_i.data[7:0], vd_sh_q[`ELEM_VREG_W-1:8]};
                msk_d   = {res_i.be, msk_q[`ELEM_VMSK_W-1:1]};
            end
        endcase
    end

    //////////////////////////////
    // registers

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            cnt_q        <= '0;
            wr_en_q      <= 1'b0;
            xreg_valid_q <= 1'b0;
        end else begin
            if (store) begin
                cnt_q <= cnt_d;
            end
            // register is full once the byte position wraps
            wr_en_q      <= store & (cnt_d.part.low == '1);
            xreg_valid_q <= res_i.valid & res_i.last & (res_i.op != elem_pkg::ELEM_VID);
        end
    end

    always_ff @(posedge clk_i) begin
        if (store) begin
            vd_sh_q   <= vd_sh_d;
            msk_q     <= msk_d;
            wr_addr_q <= res_i.vd + {2'b00, cnt_d.part.mul};
        end
        if (res_i.valid) begin
            xreg_q <= res_i.data;
        end
    end

    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = wr_addr_q;
    assign vreg_wr_o      = vd_sh_q;
    assign vreg_wr_mask_o = msk_q;
    assign xreg_valid_o   = xreg_valid_q;
    assign xreg_o         = xreg_q;

endmodule

//--- rtl/elem_unit.sv
/*
 * Element unit top level
 * decode, operand, execute and result stages in a row
 */

`timescale 1ns/1ps

`include "elem_defs.svh"

module elem_unit (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    op_rdy_i,
    input  elem_pkg::elem_op_t      op_i,
    output logic                    op_ack_o,

    // register file ports
    input  logic [`ELEM_VREG_W-1:0] vreg_rd_i,
    output logic [4:0]              vreg_rd_addr_o,
    output logic                    vreg_wr_en_o,
    output logic [4:0]              vreg_wr_addr_o,
    output logic [`ELEM_VREG_W-1:0] vreg_wr_o,
    output logic [`ELEM_VMSK_W-1:0] vreg_wr_mask_o,

    // scalar result
    output logic                    xreg_valid_o,
    output logic [`ELEM_XLEN-1:0]   xreg_o
);

    elem_pkg::elem_stage_t dec_stage;
    elem_pkg::elem_stage_t opd_stage;
    logic [`ELEM_XLEN-1:0] opd_elem;
    elem_pkg::elem_res_t   ex_res;

    elem_decode u_decode (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_rdy_i     (op_rdy_i),
        .op_i         (op_i),
        .op_ack_o     (op_ack_o),
        .stage_o      (dec_stage)
    );

    elem_operand u_operand (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .stage_i        (dec_stage),
        .vreg_rd_i      (vreg_rd_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .stage_o        (opd_stage),
        .elem_o         (opd_elem)
    );

    elem_execute u_execute (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .stage_i      (opd_stage),
        .elem_i       (opd_elem),
        .res_o        (ex_res)
    );

    elem_result u_result (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .res_i          (ex_res),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o),
        .xreg_valid_o   (xreg_valid_o),
        .xreg_o         (xreg_o)
    );

endmodule

//--- verif/tb_elem_unit.sv
/*
 * Element unit testbench
 * register file model, operation driver and result checks from a data file
 */

`timescale 1ns/1ps

`include "elem_defs.svh"

module tb_elem_unit;

    logic                    clk_i;
    logic                    async_rst_ni;
    logic                    op_rdy_i;
    elem_pkg::elem_op_t      op_i;
    logic                    op_ack_o;
    logic [`ELEM_VREG_W-1:0] vreg_rd_i;
    logic [4:0]              vreg_rd_addr_o;
    logic                    vreg_wr_en_o;
    logic [4:0]              vreg_wr_addr_o;
    logic [`ELEM_VREG_W-1:0] vreg_wr_o;
    logic [`ELEM_VMSK_W-1:0] vreg_wr_mask_o;
    logic                    xreg_valid_o;
    logic [`ELEM_XLEN-1:0]   xreg_o;

    // one data file line per entry
    logic [159:0]            stim_mem [64];
    logic [`ELEM_VREG_W-1:0] vrf [32];
    logic [`ELEM_XLEN-1:0]   exp_q [$];
    int unsigned             cycle_cnt = 0;
    int unsigned             cycle_limit = 0;

    // index operation in flight
    logic                    idx_pending = 1'b0;
    logic [4:0]              idx_vd;
    int                      idx_regs;
    int                      idx_bytes;
    int                      idx_vl;
    logic [`ELEM_VREG_W-1:0] idx_old [8];
    int                      wr_cnt;
    logic [7:0]              wr_seen;

    elem_unit uut (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_i           (op_i),
        .op_ack_o       (op_ack_o),
        .vreg_rd_i      (vreg_rd_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o),
        .xreg_valid_o   (xreg_valid_o),
        .xreg_o         (xreg_o)
    );

    always #50 clk_i = ~clk_i;

    // register file answers in the same cycle
    assign vreg_rd_i = vrf[vreg_rd_addr_o];

    //////////////////////////////
    // helpers

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input logic [`ELEM_VREG_W-1:0] actual,
                           input logic [`ELEM_VREG_W-1:0] expected,
                           input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s, got %h, expected %h",
                                    $time, what, actual, expected));
        end
    endtask

    function automatic int elem_cycles(input logic [3:0] op, input logic [1:0] sew,
                                       input logic [1:0] emul);
        if (op == elem_pkg::ELEM_XMV) begin
            return 1;
        end
        return (16 << emul) >> sew;
    endfunction

    // byte g of the group holds part of element g / size, or keeps its old value
    function automatic logic [7:0] index_byte(input int g, input int size, input int vl,
                                              input logic [7:0] old);
        int e;
        int k;
        e = g / size;
        k = g % size;
        if (e < vl) begin
            return 8'((e >> (8 * k)) & 'hff);
        end
        return old;
    endfunction

    task automatic check_index();
        logic [`ELEM_VREG_W-1:0] exp_reg;
        for (int r = 0; r < idx_regs; r++) begin
            for (int b = 0; b < 16; b++) begin
                exp_reg[8*b +: 8] = index_byte(r * 16 + b, idx_bytes, idx_vl,
                                               idx_old[r][8*b +: 8]);
            end
            compare(vrf[5'(idx_vd + r)], exp_reg,
                    $sformatf("index result in v%0d", idx_vd + r));
        end
        idx_pending = 1'b0;
    endtask

    // all scalar results returned and all index writes seen
    task automatic wait_idle();
        while (exp_q.size() != 0 || (idx_pending && wr_cnt < idx_regs)) begin
            @(negedge clk_i);
        end
        if (idx_pending) begin
            check_index();
        end
    endtask

    // called a little after a rising edge, returns the same way
    task automatic send_op(input elem_pkg::elem_op_t op, input logic [`ELEM_XLEN-1:0] expected);
        logic acked;
        acked    = 1'b0;
        op_rdy_i = 1'b1;
        op_i     = op;
        while (!acked) begin
            @(negedge clk_i);
            acked = op_ack_o;
            if (acked && op.op != elem_pkg::ELEM_VID) begin
                exp_q.push_back(expected);
            end
            @(posedge clk_i);
            #1;
        end
        op_rdy_i = 1'b0;
    endtask

    //////////////////////////////
    // monitors

    always @(negedge clk_i) begin
        if (xreg_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_on_error("scalar result strobe with no operation in flight");
            end else begin
                compare(xreg_o, exp_q.pop_front(), "scalar result");
            end
        end
    end

    // register writes applied byte by byte under the mask
    always @(negedge clk_i) begin
        int off;
        off = int'(5'(vreg_wr_addr_o - idx_vd));
        if (vreg_wr_en_o === 1'b1) begin
            if (!idx_pending) begin
                stop_on_error("register write strobe with no index operation in flight");
            end else if (off >= idx_regs) begin
                stop_on_error("register write outside the destination group");
            end else if (wr_seen[off]) begin
                stop_on_error("destination register written more than once");
            end else begin
                wr_seen[off] = 1'b1;
                for (int b = 0; b < 16; b++) begin
                    if (vreg_wr_mask_o[b]) begin
                        vrf[vreg_wr_addr_o][8*b +: 8] = vreg_wr_o[8*b +: 8];
                    end
                end
                wr_cnt++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            stop_on_error("timeout, the operations did not complete in time");
        end
    end

    //////////////////////////////
    // main sequence

    initial begin
        int                 n;
        int                 gap;
        logic [159:0]       w;
        elem_pkg::elem_op_t op;
        clk_i        = 1'b0;
        async_rst_ni = 1'b0;
        op_rdy_i     = 1'b0;
        op_i         = '0;
        wr_cnt       = 0;
        wr_seen      = '0;
        void'($urandom(32'h8bde));
        for (int a = 0; a < 32; a++) begin
            for (int b = 0; b < 16; b++) begin
                vrf[a][8*b +: 8] = 8'(a * 17 + b) ^ 8'h5a;
            end
        end
        $readmemh("verif/elem_input.txt", stim_mem);

        // reset, quiet window and margin, then each operation
        cycle_limit = 16 + 8 + 64;
        n = 0;
        while (n < 64 && stim_mem[n][159:156] !== 4'hf) begin
            if (stim_mem[n][159:156] == 4'h2) begin
                cycle_limit += elem_cycles(stim_mem[n][155:152], stim_mem[n][149:148],
                                           stim_mem[n][145:144]) + 12;
            end
            n++;
        end

        repeat (16) @(posedge clk_i);
        #1;
        async_rst_ni = 1'b1;

        // nothing may come out before the first operation
        repeat (8) begin
            @(negedge clk_i);
            compare(vreg_wr_en_o, 1'b0, "write strobe after reset");
            compare(xreg_valid_o, 1'b0, "scalar strobe after reset");
            compare(op_ack_o, 1'b0, "acknowledge after reset");
        end
        @(posedge clk_i);
        #1;

        n = 0;
        while (n < 64 && stim_mem[n][159:156] !== 4'hf) begin
            w = stim_mem[n];
            if (w[159:156] == 4'h1) begin
                vrf[w[132:128]] = w[127:0];
            end else if (w[159:156] == 4'h2) begin
                // back-to-back entries follow the previous acknowledge directly
                if (!w[112]) begin
                    wait_idle();
                    @(posedge clk_i);
                    #1;
                    gap = $urandom % 4;
                    repeat (gap) begin
                        @(posedge clk_i);
                        #1;
                    end
                end
                op.op   = elem_pkg::elem_op_e'(w[155:152]);
                op.sew  = elem_pkg::elem_sew_e'(w[149:148]);
                op.emul = elem_pkg::elem_emul_e'(w[145:144]);
                op.vl   = w[143:136];
                op.vs2  = w[132:128];
                op.vd   = w[124:120];
                if (op.op == elem_pkg::ELEM_VID) begin
                    idx_vd    = op.vd;
                    idx_regs  = 1 << w[145:144];
                    idx_bytes = 1 << w[149:148];
                    idx_vl    = int'(op.vl);
                    wr_cnt    = 0;
                    wr_seen   = '0;
                    for (int r = 0; r < idx_regs; r++) begin
                        idx_old[r] = vrf[5'(op.vd + r)];
                    end
                    idx_pending = 1'b1;
                end
                send_op(op, w[31:0]);
            end
            n++;
        end
        wait_idle();

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
rtl/elem_pkg.sv
rtl/elem_decode.sv
rtl/elem_operand.sv
rtl/elem_execute.sv
rtl/elem_result.sv
rtl/elem_unit.sv
verif/tb_elem_unit.sv

//--- verif/elem_input.txt
// kind 1: register load  kind op sew emul vl reg_data(reg) data(128 bits)
// kind 2: operation  kind op sew emul vl vs2 vd b2b pad expected, kind f ends the list
1_0_0_0_00_02_44332211_7f8002fe_01401004_7123859c
1_0_0_0_00_04_00000004_00000003_00000002_00000001
1_0_0_0_00_05_00000040_00000030_00000020_00000010
1_0_0_0_00_08_00000008_00000004_00000002_00000001
1_0_0_0_00_09_00000080_00000040_00000020_00000010
1_0_0_0_00_0a_00000800_00000400_00000200_00000100
1_0_0_0_00_0b_00008000_00004000_00002000_00001000
1_0_0_0_00_0c_12345678_f3ffffff_fff0f0ff_f0f0ff0f
1_0_0_0_00_0e_07060504_0302017f_80ff007e_f0059040
1_0_0_0_00_0f_7fff8000_00000100_c0007ffe_80011234
1_0_0_0_00_14_a7a6a5a4_a3a2a1a0_afaeadac_abaaa9a8
1_0_0_0_00_15_5f5e5d5c_5b5a5958_57565554_53525150
2_0_0_0_01_02_00_00_00000000_00000000_0000_ffffff9c
2_0_1_0_01_02_00_00_00000000_00000000_0000_ffff859c
2_0_2_0_01_02_00_00_00000000_00000000_0000_7123859c
2_1_2_1_06_04_00_00_00000000_00000000_0000_0000003a
2_1_1_2_20_08_00_00_00000000_00000000_0000_ffffffff
2_2_0_0_02_02_00_00_00000000_00000000_0000_ffffff84
2_2_2_0_03_0c_00_00_00000000_00000000_0000_f0f0f00f
2_3_2_2_10_08_00_00_00000000_00000000_0000_0000ffff
2_4_0_0_10_02_00_00_00000000_00000000_0000_00000059
2_4_2_2_0d_08_00_00_00000000_00000000_0000_00001fff
2_5_0_0_05_0e_00_00_00000000_00000000_0000_00000005
2_6_0_0_05_0e_00_00_00000000_00000000_0000_ffffff90
2_7_0_0_05_0e_00_00_00000000_00000000_0000_fffffff0
2_8_0_0_05_0e_00_00_00000000_00000000_0000_0000007e
2_5_1_0_05_0f_00_00_00000000_00000000_0000_00000100
2_6_1_0_05_0f_00_00_00000000_00000000_0000_ffff8001
2_7_1_0_05_0f_00_00_00000000_00000000_0000_ffffc000
2_8_1_0_05_0f_00_00_00000000_00000000_0000_00007ffe
2_9_0_1_14_00_14_00_00000000_00000000_0000_00000000
2_9_1_1_0b_00_16_00_00000000_00000000_0000_00000000
2_9_2_1_07_00_18_00_00000000_00000000_0000_00000000
2_1_2_1_08_04_00_00_00000000_00000000_0000_000000aa
2_0_2_0_01_0c_00_01_00000000_00000000_0000_f0f0ff0f
2_0_0_0_01_0e_00_00_00000000_00000000_0000_00000040
2_8_0_0_05_0e_00_01_00000000_00000000_0000_0000007e
f_0_0_0_00_00_00000000_00000000_00000000_00000000
